// File: files.f
hw/ctrlPkg.sv
hw/instrDecode.sv
hw/stepSequencer.sv
hw/controlWordGen.sv
hw/controlUnit.sv
tests/controlUnitTb.sv

// File: hw/controlUnit.sv
module controlUnit (
  input  logic                  Clock,
  input  logic                  rstN,
  input  ctrlPkg::instrWordT    instrWord,
  output logic                  pcWrite,
  output logic                  pcWriteCond,
  output logic                  pcWriteCondNe,
  output logic                  memWrite,
  output logic                  iOrD,
  output logic                  irWrite,
  output logic                  regWrite,
  output logic                  regDst,
  output logic                  aluSrcA,
  output logic                  regALoad,
  output logic                  regBLoad,
  output logic                  aluOutLoad,
  output logic                  mdrLoad,
  output logic                  halted,
  output logic [1:0]            pcSource,
  output logic [1:0]            aluSrcB,
  output logic [1:0]            aluOp,
  output logic [1:0]            memToReg
);

  import ctrlPkg::*;

  logic [classW-1:0] instrClass;
  logic [phaseW-1:0] phase;
  logic [stepW-1:0] step;

  instrDecode uDecode (
    .Clock(Clock),
    .rstN(rstN),
    .irWrite(irWrite), // loads from the table's own strobe
    .instrWord(instrWord),
    .instrClass(instrClass)
  );

  stepSequencer uSeq (
    .Clock(Clock),
    .rstN(rstN),
    .instrClass(instrClass),
    .phase(phase),
    .step(step),
    .halted(halted)
  );

  controlWordGen uGen (
    .phase(phase),
    .step(step),
    .instrClass(instrClass),
    .pcWrite(pcWrite),
    .pcWriteCond(pcWriteCond),
    .pcWriteCondNe(pcWriteCondNe),
    .memWrite(memWrite),
    .iOrD(iOrD),
    .irWrite(irWrite),
    .regWrite(regWrite),
    .regDst(regDst),
    .aluSrcA(aluSrcA),
    .regALoad(regALoad),
    .regBLoad(regBLoad),
    .aluOutLoad(aluOutLoad),
    .mdrLoad(mdrLoad),
    .pcSource(pcSource),
    .aluSrcB(aluSrcB),
    .aluOp(aluOp),
    .memToReg(memToReg)
  );

endmodule

// File: hw/controlWordGen.sv
module controlWordGen (
  input  logic [ctrlPkg::phaseW-1:0]    phase,
  input  logic [ctrlPkg::stepW-1:0]     step,
  input  logic [ctrlPkg::classW-1:0]    instrClass,
  output logic                          pcWrite,
  output logic                          pcWriteCond,
  output logic                          pcWriteCondNe,
  output logic                          memWrite,
  output logic                          iOrD,
  output logic                          irWrite,
  output logic                          regWrite,
  output logic                          regDst,
  output logic                          aluSrcA,
  output logic                          regALoad,
  output logic                          regBLoad,
  output logic                          aluOutLoad,
  output logic                          mdrLoad,
  output logic [1:0]                    pcSource,
  output logic [1:0]                    aluSrcB,
  output logic [1:0]                    aluOp,
  output logic [1:0]                    memToReg
);

  import ctrlPkg::*;

  always_comb begin
    pcWrite = 1'b0;
    pcWriteCond = 1'b0;
    pcWriteCondNe = 1'b0;
    memWrite = 1'b0;
    iOrD = 1'b0;
    irWrite = 1'b0;
    regWrite = 1'b0;
    regDst = 1'b0;
    aluSrcA = 1'b0;
    regALoad = 1'b0;
    regBLoad = 1'b0;
    aluOutLoad = 1'b0;
    mdrLoad = 1'b0;
    pcSource = pcSrcAlu;
    aluSrcB = srcBRegB;
    aluOp = aluOpAdd;
    memToReg = memToRegAlu;

    case (phase)
      phFetch: begin
        pcWrite = 1'b1; // pc + 4
        aluSrcB = srcBFour;
      end
      phIrWrite: begin
        irWrite = 1'b1;
      end
      phDecode: begin
        if (instrClass == clsJump) begin
          pcWrite = 1'b1;
          pcSource = pcSrcJump;
        end
        if (instrClass == clsAddi) regALoad = 1'b1; // rs ready for the first execute step
      end
      phExec: begin
        case (instrClass)
          clsAlu: begin
            regDst = 1'b1;
            case (step)
              3'd0: begin
                regALoad = 1'b1;
                regBLoad = 1'b1;
              end
              3'd1: begin
                aluSrcA = 1'b1;
                aluOp = aluOpFunct;
                aluOutLoad = 1'b1;
              end
              default: regWrite = 1'b1;
            endcase
          end
          clsJr: begin
            aluSrcA = 1'b1;
            if (step == 3'd0) regALoad = 1'b1;
            else pcWrite = 1'b1; // rs through the ALU into pc
          end
          clsAddi: begin
            aluSrcA = 1'b1;
            aluSrcB = srcBImm;
            if (step == 3'd0) aluOutLoad = 1'b1;
            else regWrite = 1'b1;
          end
          clsLw: begin
            case (step)
              3'd0: begin
                regALoad = 1'b1;
                regBLoad = 1'b1;
              end
              3'd1: begin
                aluSrcA = 1'b1;
                aluSrcB = srcBImm;
                aluOutLoad = 1'b1;
              end
              3'd2, 3'd3, 3'd4: iOrD = 1'b1; // fixed memory read latency
              3'd5: mdrLoad = 1'b1;
              default: begin
                regWrite = 1'b1;
                memToReg = memToRegMdr;
              end
            endcase
          end
          clsSw: begin
            case (step)
              3'd0: begin
                regALoad = 1'b1;
                regBLoad = 1'b1;
              end
              3'd1: begin
                aluSrcA = 1'b1;
                aluSrcB = srcBImm;
                aluOutLoad = 1'b1;
              end
              default: begin
                memWrite = 1'b1;
                iOrD = 1'b1;
              end
            endcase
          end
          clsBeq, clsBne: begin
            case (step)
              3'd0: begin
                aluSrcB = srcBImmShift; // pc + offset
                aluOutLoad = 1'b1;
              end
              3'd1: begin
                regALoad = 1'b1;
                regBLoad = 1'b1;
              end
              default: begin
                aluSrcA = 1'b1;
                aluOp = aluOpSub;
                pcSource = pcSrcAluOut;
                pcWriteCond = (instrClass == clsBeq);
                pcWriteCondNe = (instrClass == clsBne);
              end
            endcase
          end
          default: begin
          end
        endcase
      end
      default: begin
      end
    endcase
  end

  noPcMemWrite: assert final (!(pcWrite && memWrite))
    else $error("controlWordGen: pcWrite and memWrite together");

endmodule

// File: hw/ctrlPkg.sv
package ctrlPkg;

  localparam int instrW = 32;
  localparam int opW = 6;
  localparam int classW = 4;
  localparam int phaseW = 3;
  localparam int stepW = 3;

  // opcode field values
  localparam logic [opW-1:0] opRType = 6'b000000;
  localparam logic [opW-1:0] opJ = 6'b000010;
  localparam logic [opW-1:0] opBeq = 6'b000100;
  localparam logic [opW-1:0] opBne = 6'b000101;
  localparam logic [opW-1:0] opAddi = 6'b001000;
  localparam logic [opW-1:0] opLw = 6'b100011;
  localparam logic [opW-1:0] opSw = 6'b101011;

  // funct field values, only meaningful with opRType
  localparam logic [opW-1:0] fnJr = 6'b001000;
  localparam logic [opW-1:0] fnBreak = 6'b001101;

  localparam logic [classW-1:0] clsAlu = 4'd0;
  localparam logic [classW-1:0] clsJr = 4'd1;
  localparam logic [classW-1:0] clsAddi = 4'd2;
  localparam logic [classW-1:0] clsLw = 4'd3;
  localparam logic [classW-1:0] clsSw = 4'd4;
  localparam logic [classW-1:0] clsBeq = 4'd5;
  localparam logic [classW-1:0] clsBne = 4'd6;
  localparam logic [classW-1:0] clsJump = 4'd7;
  localparam logic [classW-1:0] clsBreak = 4'd8;
  localparam logic [classW-1:0] clsUnknown = 4'd9; // highest legal class code

  localparam logic [phaseW-1:0] phFetch = 3'd0;
  localparam logic [phaseW-1:0] phFetchWait = 3'd1;
  localparam logic [phaseW-1:0] phIrWrite = 3'd2;
  localparam logic [phaseW-1:0] phDecode = 3'd3;
  localparam logic [phaseW-1:0] phExec = 3'd4;
  localparam logic [phaseW-1:0] phHalt = 3'd5;

  // execute steps after decode, per class
  localparam logic [stepW-1:0] execLenAlu = 3'd3;
  localparam logic [stepW-1:0] execLenJr = 3'd2;
  localparam logic [stepW-1:0] execLenAddi = 3'd2;
  localparam logic [stepW-1:0] execLenLw = 3'd7;
  localparam logic [stepW-1:0] execLenSw = 3'd3;
  localparam logic [stepW-1:0] execLenBeq = 3'd3;
  localparam logic [stepW-1:0] execLenBne = 3'd3;
  localparam logic [stepW-1:0] execLenJump = 3'd0;
  localparam logic [stepW-1:0] execLenUnknown = 3'd0;
  localparam logic [stepW-1:0] execLenBreak = 3'd0;

  localparam logic [1:0] pcSrcAlu = 2'b00;
  localparam logic [1:0] pcSrcAluOut = 2'b01; // branch target held in aluOut
  localparam logic [1:0] pcSrcJump = 2'b10;

  localparam logic [1:0] aluOpAdd = 2'b00;
  localparam logic [1:0] aluOpSub = 2'b01;
  localparam logic [1:0] aluOpFunct = 2'b10;

  localparam logic [1:0] srcBRegB = 2'b00;
  localparam logic [1:0] srcBFour = 2'b01;
  localparam logic [1:0] srcBImm = 2'b10;
  localparam logic [1:0] srcBImmShift = 2'b11;

  localparam logic [1:0] memToRegAlu = 2'b00;
  localparam logic [1:0] memToRegMdr = 2'b01;

  typedef struct packed {
    logic [opW-1:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [opW-1:0] funct;
  } rTypeT;

  typedef struct packed {
    logic [opW-1:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [instrW/2-1:0] imm;
  } iTypeT;

  typedef union packed {
    rTypeT r;
    iTypeT i;
  } instrWordT;

endpackage

// File: hw/instrDecode.sv
module instrDecode (
  input  logic                          Clock,
  input  logic                          rstN,
  input  logic                          irWrite,
  input  ctrlPkg::instrWordT            instrWord,
  output logic [ctrlPkg::classW-1:0]    instrClass
);

  import ctrlPkg::*;

  instrWordT instrReg;
  logic [opW-1:0] opcode;
  logic [opW-1:0] funct;

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      instrReg <= '0;
    end else if (irWrite) begin
      instrReg <= instrWord;
    end
  end

  assign opcode = instrReg.i.opcode; // opcode sits in the same bits in both views
  assign funct = instrReg.r.funct;

  always_comb begin
    instrClass = clsUnknown;
    case (opcode)
      opRType: begin
        case (funct)
          fnJr: instrClass = clsJr;
          fnBreak: instrClass = clsBreak;
          default: instrClass = clsAlu; // any other funct goes to the ALU
        endcase
      end
      opAddi: begin
        instrClass = clsAddi;
      end
      opLw: begin
        instrClass = clsLw;
      end
      opSw: begin
        instrClass = clsSw;
      end
      opBeq: begin
        instrClass = clsBeq;
      end
      opBne: begin
        instrClass = clsBne;
      end
      opJ: begin
        instrClass = clsJump;
      end
      default: begin
        instrClass = clsUnknown;
      end
    endcase
  end

  // the class seen by the sequencer and the control table is always one they know
  classDefined: assert property (
    @(posedge Clock) disable iff (!rstN)
    !$isunknown(instrClass) && (instrClass <= clsUnknown)
  ) else $error("instrDecode: undefined class %0d", instrClass);

endmodule

// File: hw/stepSequencer.sv
module stepSequencer (
  input  logic                          Clock,
  input  logic                          rstN,
  input  logic [ctrlPkg::classW-1:0]    instrClass,
  output logic [ctrlPkg::phaseW-1:0]    phase,
  output logic [ctrlPkg::stepW-1:0]     step,
  output logic                          halted
);

  import ctrlPkg::*;

  logic [stepW-1:0] curLen;
  logic [stepW-1:0] lastStep;

  // execute length of the held class
  function automatic logic [stepW-1:0] lenOf(input logic [classW-1:0] cls);
    case (cls)
      clsAlu: return execLenAlu;
      clsJr: return execLenJr;
      clsAddi: return execLenAddi;
      clsLw: return execLenLw;
      clsSw: return execLenSw;
      clsBeq: return execLenBeq;
      clsBne: return execLenBne;
      clsJump: return execLenJump;
      clsBreak: return execLenBreak;
      default: return execLenUnknown;
    endcase
  endfunction

  assign curLen = lenOf(instrClass);
  assign lastStep = curLen - stepW'(1);

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      phase <= phFetch;
      step <= '0;
    end else begin
      case (phase)
        phFetch: phase <= phFetchWait;
        phFetchWait: phase <= phIrWrite;
        phIrWrite: phase <= phDecode;
        phDecode: begin
          step <= '0;
          if (instrClass == clsBreak) begin
            phase <= phHalt;
          end else if (curLen != '0) begin
            phase <= phExec;
          end else begin
            phase <= phFetch; // j and unknown opcodes
          end
        end
        phExec: begin
          if (step == lastStep) begin
            phase <= phFetch;
            step <= '0;
          end else begin
            step <= step + stepW'(1);
          end
        end
        phHalt: phase <= phHalt; // only reset leaves here
        default: phase <= phFetch;
      endcase
    end
  end

  assign halted = (phase == phHalt);

  stepInRange: assert property (
    @(posedge Clock) disable iff (!rstN)
    (phase == phExec) |-> (step < curLen)
  ) else $error("stepSequencer: step %0d past length %0d", step, curLen);

endmodule

// File: tests/controlUnitTb.sv
module controlUnitTb;

  timeunit 1ns;
  timeprecision 100ps;

  import ctrlPkg::*;

  localparam int maxTests = 32;
  localparam int cols = 8; // fields per stim line
  localparam int haltWatch = 20;

  logic Clock;
  logic rstN;
  instrWordT instrWord;
  logic pcWrite, pcWriteCond, pcWriteCondNe, memWrite, iOrD, irWrite;
  logic regWrite, regDst, aluSrcA, regALoad, regBLoad, aluOutLoad, mdrLoad, halted;
  logic [1:0] pcSource, aluSrcB, aluOp, memToReg;
  logic fetchSeen;

  logic [7:0] stimMem [0:maxTests*cols-1];
  int nTests, limit, cycleCount;
  int checks, errors, testErrs;
  int regCnt, memCnt, condCnt, condNeCnt, mdrCnt, jumpCnt, badIOrD, earlyWrite;
  int functCnt, immCnt, targetCnt, loadACnt, loadBCnt, jrCnt;
  int regAt, mdrAt, dstAt, m2rAt;
  bit seenIrWrite;

  controlUnit dut (
    .Clock(Clock), .rstN(rstN), .instrWord(instrWord),
    .pcWrite(pcWrite), .pcWriteCond(pcWriteCond), .pcWriteCondNe(pcWriteCondNe),
    .memWrite(memWrite), .iOrD(iOrD), .irWrite(irWrite), .regWrite(regWrite),
    .regDst(regDst), .aluSrcA(aluSrcA), .regALoad(regALoad), .regBLoad(regBLoad),
    .aluOutLoad(aluOutLoad), .mdrLoad(mdrLoad), .halted(halted),
    .pcSource(pcSource), .aluSrcB(aluSrcB), .aluOp(aluOp), .memToReg(memToReg)
  );

  // jr also writes pc through the ALU, but with rs on source A
  assign fetchSeen = pcWrite && (pcSource == pcSrcAlu) && !aluSrcA;

  initial begin
    Clock = 1'b0;
    forever #2 Clock = ~Clock;
  end

  always @(posedge Clock) begin
    cycleCount++;
    if (limit > 0 && cycleCount > limit) begin
      $display("timeout: no progress after %0d cycles", cycleCount);
      $display("Simulation failed");
      $finish;
    end
  end

  // cycles from fetch to fetch, as the package lengths give them
  function automatic int pkgCycles(input logic [opW-1:0] op, input logic [opW-1:0] fn);
    case (op)
      opRType: begin
        if (fn == fnJr) return 4 + execLenJr;
        if (fn == fnBreak) return 4 + execLenBreak;
        return 4 + execLenAlu;
      end
      opAddi: return 4 + execLenAddi;
      opLw: return 4 + execLenLw;
      opSw: return 4 + execLenSw;
      opBeq: return 4 + execLenBeq;
      opBne: return 4 + execLenBne;
      opJ: return 4 + execLenJump;
      default: return 4 + execLenUnknown;
    endcase
  endfunction

  task automatic checkValue(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      testErrs++;
      $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, exp, got);
    end
  endtask

  task automatic checkTrue(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      testErrs++;
      $display("ERROR at %0t: %s", $time, what);
    end
  endtask

  task automatic clearCounts();
    regCnt = 0;
    memCnt = 0;
    condCnt = 0;
    condNeCnt = 0;
    mdrCnt = 0;
    jumpCnt = 0;
    badIOrD = 0;
    functCnt = 0;
    immCnt = 0;
    targetCnt = 0;
    loadACnt = 0;
    loadBCnt = 0;
    jrCnt = 0;
    regAt = 0;
    mdrAt = 0;
    dstAt = 0;
    m2rAt = 0;
  endtask

  task automatic tally(input int cyc);
    if (!seenIrWrite && (regWrite || memWrite)) earlyWrite++;
    if (irWrite) seenIrWrite = 1'b1;
    if (regWrite) begin
      regCnt++;
      regAt = cyc;
      dstAt = regDst;
      m2rAt = memToReg;
    end
    if (mdrLoad) begin
      mdrCnt++;
      mdrAt = cyc;
    end
    if (memWrite) memCnt++;
    if (memWrite && !iOrD) badIOrD++; // store address must come from aluOut
    if (pcWriteCond) condCnt++;
    if (pcWriteCondNe) condNeCnt++;
    if (pcWrite && pcSource == pcSrcJump) jumpCnt++;
    if (pcWrite && aluSrcA) jrCnt++;
    if (regALoad) loadACnt++;
    if (regBLoad) loadBCnt++;
    if (aluOutLoad && aluOp == aluOpFunct) functCnt++;
    if (aluOutLoad && aluSrcB == srcBImm) immCnt++; // base plus offset
    if (aluOutLoad && aluSrcB == srcBImmShift) targetCnt++;
  endtask

  // entered at the negedge of a fetch cycle, returns at the next one
  task automatic runTest(input int t);
    logic [opW-1:0] op;
    logic [opW-1:0] fn;
    instrWordT w;
    int cycles;
    int irAfter;
    int lowAfter;
    bit isBreak;
    bit isJr;
    bit isAlu;
    bit isLw;
    bit isSw;
    bit isAddi;
    bit isBranch;
    bit usesB;
    bit done;
    op = stimMem[t*cols][opW-1:0];
    fn = stimMem[t*cols+1][opW-1:0];
    isBreak = (op == opRType) && (fn == fnBreak);
    isJr = (op == opRType) && (fn == fnJr);
    isAlu = (op == opRType) && !isJr && !isBreak;
    isLw = (op == opLw);
    isSw = (op == opSw);
    isAddi = (op == opAddi);
    isBranch = (op == opBeq) || (op == opBne);
    usesB = isAlu || isLw || isSw || isBranch;
    testErrs = 0;
    w = $urandom; // register fields and immediate stay random
    w.i.opcode = op;
    if (op == opRType) w.r.funct = fn;
    checkValue("stim cycles vs package", int'(stimMem[t*cols+2]), pkgCycles(op, fn));
    clearCounts();
    cycles = 1;
    tally(cycles);
    @(posedge Clock);
    #1 instrWord = w;
    done = 1'b0;
    while (!done) begin
      @(negedge Clock);
      if (isBreak && halted) begin
        done = 1'b1;
      end else if (fetchSeen) begin
        done = 1'b1;
      end else begin
        cycles++;
        tally(cycles);
      end
    end
    checkValue("cycles", cycles, int'(stimMem[t*cols+2]));
    checkValue("regWrite", regCnt, int'(stimMem[t*cols+3]));
    checkValue("memWrite", memCnt, int'(stimMem[t*cols+4]));
    checkValue("pcWriteCond", condCnt, int'(stimMem[t*cols+5]));
    checkValue("pcWriteCondNe", condNeCnt, int'(stimMem[t*cols+6]));
    checkValue("mdrLoad", mdrCnt, int'(stimMem[t*cols+7]));
    checkValue("jump pcWrite", jumpCnt, (op == opJ) ? 1 : 0);
    checkValue("memWrite without iOrD", badIOrD, 0);
    checkValue("jr pcWrite", jrCnt, isJr ? 1 : 0);
    checkValue("regALoad", loadACnt, (usesB || isJr || isAddi) ? 1 : 0);
    checkValue("regBLoad", loadBCnt, usesB ? 1 : 0);
    checkValue("aluOp funct", functCnt, isAlu ? 1 : 0);
    checkValue("aluSrcB imm", immCnt, (isLw || isSw || isAddi) ? 1 : 0);
    checkValue("aluSrcB branch target", targetCnt, isBranch ? 1 : 0);
    if (regCnt > 0) begin
      checkValue("regDst", dstAt, isAlu ? 1 : 0);
      checkValue("memToReg", m2rAt, isLw ? int'(memToRegMdr) : int'(memToRegAlu));
    end
    if (t == 0) checkValue("regWrite/memWrite before first irWrite", earlyWrite, 0);
    if (op == opLw) checkTrue(mdrAt > 0 && regAt > mdrAt, "lw regWrite did not follow mdrLoad");
    if (isBreak) begin
      checkTrue(halted, "break did not raise halted");
      irAfter = 0;
      lowAfter = 0;
      repeat (haltWatch) begin
        @(negedge Clock);
        if (irWrite) irAfter++;
        if (!halted) lowAfter++;
      end
      checkValue("irWrite after halt", irAfter, 0);
      checkValue("cycles with halted low", lowAfter, 0);
    end
    $display("test %0d op %h fn %h: %0d cycles, %s", t, op, fn, cycles,
             (testErrs == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    int sumCycles;
    rstN = 1'b0;
    instrWord = '0;
    limit = 0;
    cycleCount = 0;
    checks = 0;
    errors = 0;
    earlyWrite = 0;
    seenIrWrite = 1'b0;
    nTests = 0;
    sumCycles = 0;
    void'($urandom(32'h5498bc7d));
    for (int k = 0; k < maxTests*cols; k++) stimMem[k] = 8'hff; // ff marks an empty line
    $readmemh("tests/ctrlStim.txt", stimMem);
    for (int k = 0; k < maxTests; k++) begin
      if (stimMem[k*cols] !== 8'hff) begin
        nTests = k + 1;
        sumCycles += int'(stimMem[k*cols+2]);
      end
    end
    limit = 2 * sumCycles + 40;
    checkTrue(nTests > 0, "no tests read from the stim file");

    repeat (2) @(posedge Clock);
    #1 rstN = 1'b1;
    @(negedge Clock);
    testErrs = 0;
    checkValue("pcWrite", int'(pcWrite), 1);
    checkValue("pcSource", int'(pcSource), int'(pcSrcAlu));
    checkValue("aluSrcB", int'(aluSrcB), int'(srcBFour));
    $display("reset: first cycle %s", (testErrs == 0) ? "fetches" : "FAILED");

    for (int t = 0; t < nTests; t++) runTest(t);

    $display("tests %0d, checks %0d, errors %0d", nTests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tests/ctrlStim.txt
// columns: opcode funct cycles regWrite memWrite pcWriteCond pcWriteCondNe mdrLoad (hex)
// cycles run from one fetch pulse to the next; break counts up to halt and must come last
00 20 07 01 00 00 00 00 // add
00 22 07 01 00 00 00 00 // sub
00 24 07 01 00 00 00 00 // and
00 25 07 01 00 00 00 00 // or
00 2a 07 01 00 00 00 00 // slt
00 00 07 01 00 00 00 00 // sll funct now runs as a plain ALU op
00 08 06 00 00 00 00 00 // jr
08 00 06 01 00 00 00 00 // addi
23 00 0b 01 00 00 00 01 // lw
2b 00 07 00 01 00 00 00 // sw
04 00 07 00 00 01 00 00 // beq
05 00 07 00 00 00 01 00 // bne
02 00 04 00 00 00 00 00 // j
0f 00 04 00 00 00 00 00 // lui is no longer decoded
3f 00 04 00 00 00 00 00 // unknown opcode
23 00 0b 01 00 00 00 01 // lw
08 00 06 01 00 00 00 00 // addi
2b 00 07 00 01 00 00 00 // sw
04 00 07 00 00 01 00 00 // beq
02 00 04 00 00 00 00 00 // j
00 20 07 01 00 00 00 00 // add
00 0d 04 00 00 00 00 00 // break
